/* project.f */
+incdir+verilog
verilog/ooo_pkg.sv
verilog/dispatch_stage.sv
verilog/busy_scoreboard.sv
verilog/alu_issue_queue.sv
verilog/phys_regfile.sv
verilog/alu_execute.sv
verilog/ooo_backend_top.sv
tests/backend_assertions.sv
tests/backend_checker.sv
tests/backend_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module backend_tb -Mdir obj_dir

./obj_dir/Vbackend_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

/* tests/backend_tb.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module backend_tb;

    localparam int NTESTS  = 6;
    localparam int TIMEOUT = 300;
    localparam int NRAND   = 40;

    logic          clk;
    logic          rst;
    logic          uop_valid;
    ooo_pkg::uop_t uop;
    logic          dispatch_ready;
    logic          wb_valid;
    ooo_pkg::wb_t  wb;

    // test table: name, random flag, slice of the directed program
    string names [NTESTS] = '{"reset_li", "indep_li", "chain_ops",
                              "out_of_order", "queue_fill", "random"};
    bit    rnd [NTESTS] = '{0, 0, 0, 0, 0, 1};
    int    first [NTESTS];
    int    count [NTESTS];
    ooo_pkg::uop_t prog [64];
    int    nprog;
    int    tags [64];
    int    next_tag;
    bit    ready_low_seen;

    ooo_backend_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .uop_valid_i      (uop_valid),
        .uop_i            (uop),
        .dispatch_ready_o (dispatch_ready),
        .wb_valid_o       (wb_valid),
        .wb_o             (wb)
    );

    backend_checker chk0 (
        .clk              (clk),
        .rst              (rst),
        .uop_valid_i      (uop_valid),
        .dispatch_ready_i (dispatch_ready),
        .uop_i            (uop),
        .wb_valid_i       (wb_valid),
        .wb_i             (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // dispatch_ready_o watched at every falling edge
    always @(negedge clk) begin
        if (!rst && !dispatch_ready) begin
            ready_low_seen = 1'b1;
        end
    end

    task automatic add_uop(ooo_pkg::alu_op_e op, int s1, int s2, int d, logic [15:0] imm);
        ooo_pkg::uop_t u;
        u = '0;
        u.op   = op;
        u.src1 = 6'(s1);
        u.src2 = 6'(s2);
        u.dst  = 6'(d);
        u.imm  = imm;
        prog[nprog] = u;
        nprog++;
    endtask

    task automatic build_programs();
        nprog = 0;
        first[0] = nprog;
        add_uop(ooo_pkg::LI, 0, 0, 1, 16'h8001);
        first[1] = nprog;
        add_uop(ooo_pkg::LI, 0, 0, 2, 16'h7fff);
        add_uop(ooo_pkg::LI, 0, 0, 3, 16'hffff);
        add_uop(ooo_pkg::LI, 0, 0, 4, 16'h0010);
        add_uop(ooo_pkg::LI, 0, 0, 5, 16'h8000);
        first[2] = nprog;
        add_uop(ooo_pkg::ADD, 2, 3, 6, 16'h0);
        add_uop(ooo_pkg::SUB, 6, 4, 7, 16'h0);
        add_uop(ooo_pkg::AND, 7, 2, 8, 16'h0);
        add_uop(ooo_pkg::OR, 8, 5, 9, 16'h0);
        add_uop(ooo_pkg::XOR, 9, 3, 10, 16'h0);
        add_uop(ooo_pkg::SLT, 10, 4, 11, 16'h0);
        add_uop(ooo_pkg::SLT, 4, 10, 17, 16'h0);
        first[3] = nprog;
        add_uop(ooo_pkg::LI, 0, 0, 12, 16'h0003);
        add_uop(ooo_pkg::ADD, 12, 12, 13, 16'h0);
        add_uop(ooo_pkg::ADD, 13, 13, 14, 16'h0);
        add_uop(ooo_pkg::ADD, 14, 14, 15, 16'h0);
        add_uop(ooo_pkg::LI, 0, 0, 16, 16'h0042);
        first[4] = nprog;
        for (int k = 0; k < 12; k++) begin
            add_uop(ooo_pkg::ADD, (k == 0) ? 1 : 19 + k, 2, 20 + k, 16'h0);
        end
        first[5] = nprog;
        for (int r = 0; r < NTESTS - 1; r++) begin
            count[r] = first[r + 1] - first[r];
        end
        count[5] = NRAND;
    endtask

    function automatic ooo_pkg::uop_t random_uop();
        ooo_pkg::uop_t u;
        u.tag  = '0;
        u.op   = ooo_pkg::alu_op_e'(3'($urandom_range(6, 0)));
        u.src1 = 6'($urandom_range(63, 0));
        u.src2 = 6'($urandom_range(63, 0));
        u.dst  = 6'($urandom_range(63, 1));
        u.imm  = 16'($urandom);
        return u;
    endfunction

    // holds the micro-op until dispatch_ready is high at a falling edge
    task automatic send(ooo_pkg::uop_t u, output int tag);
        int t;
        @(negedge clk);
        u.tag = 6'(next_tag);
        tag = next_tag;
        next_tag = (next_tag + 1) % 64;
        t = 0;
        while (!(chk0.tag_free(tag) && chk0.reg_free(int'(u.dst))) && t < TIMEOUT) begin
            uop_valid = 1'b0;
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            chk0.note_fail("stuck waiting for a free tag or destination");
        end
        uop_valid = 1'b1;
        uop = u;
        t = 0;
        while (!dispatch_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            chk0.note_fail("dispatch never became ready, pipeline stuck");
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (chk0.pend_cnt != 0 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            chk0.note_fail("pipeline stuck, writebacks still missing");
        end
    endtask

    initial begin
        int n;
        void'($urandom(15817));
        rst = 1'b1;
        uop_valid = 1'b0;
        uop = '0;
        next_tag = 0;
        ready_low_seen = 1'b0;
        build_programs();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NTESTS; r++) begin
            chk0.start_test(names[r]);
            ready_low_seen = 1'b0;
            if (r == 0) begin
                chk0.compare("wb_valid_o after reset", 32'd0, 32'(wb_valid));
                chk0.compare("dispatch_ready_o after reset", 32'd1, 32'(dispatch_ready));
            end
            n = count[r];
            for (int i = 0; i < n; i++) begin
                send(rnd[r] ? random_uop() : prog[first[r] + i], tags[i]);
            end
            @(negedge clk);
            uop_valid = 1'b0;
            wait_idle();
            case (r)
                0: chk0.compare("li latency", 32'd3, 32'(chk0.lat[tags[0]]));
                3: if (chk0.wb_order[tags[4]] > chk0.wb_order[tags[3]]) begin
                    chk0.note_fail("independent li did not overtake the waiting chain");
                end
                4: if (!ready_low_seen) begin
                    chk0.note_fail("dispatch_ready_o never went low with a full queue");
                end
                default: ;
            endcase
            if (dut0.u_assert.fail_cnt != 0) begin
                chk0.note_fail("a bound assertion fired");
            end
            chk0.end_test();
        end
        chk0.report();
        if (chk0.err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // last resort if a wait loop itself never returns
    initial begin
        #2000000;
        $display("global time limit reached, pipeline stuck");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tests/backend_checker.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module backend_checker (
    input logic          clk,
    input logic          rst,
    input logic          uop_valid_i,
    input logic          dispatch_ready_i,
    input ooo_pkg::uop_t uop_i,
    input logic          wb_valid_i,
    input ooo_pkg::wb_t  wb_i
);

    localparam int NTAG = 1 << `OOO_TAG_W;

    // architectural model, updated in program order at dispatch
    logic [`OOO_XLEN-1:0] model_q [`OOO_PRF_NUM];
    bit    wr_pend [`OOO_PRF_NUM];
    int    wr_tag [`OOO_PRF_NUM];
    int    rd_cnt [`OOO_PRF_NUM];
    // in-flight micro-ops by tag
    bit    pend_v [NTAG];
    int    pend_seq [NTAG];
    logic [`OOO_XLEN-1:0] exp_data [NTAG];
    int    exp_dst [NTAG];
    bit    has_src [NTAG];
    int    src_reg [NTAG][2];
    bit    dep_v [NTAG][2];
    int    dep_tag [NTAG][2];
    int    dep_seq [NTAG][2];
    int    acc_cyc [NTAG];
    int    lat [NTAG];
    int    wb_order [NTAG];
    int    cyc;
    int    seq_cnt;
    int    wb_cnt;
    int    pend_cnt;
    int    test_err;
    int    err_cnt;
    int    pass_tests;
    int    fail_tests;
    string test_name;

    initial begin
        for (int i = 0; i < `OOO_PRF_NUM; i++) begin
            model_q[i] = '0;
            wr_pend[i] = 1'b0;
            rd_cnt[i]  = 0;
        end
        for (int i = 0; i < NTAG; i++) begin
            pend_v[i] = 1'b0;
        end
        cyc = 0;
        seq_cnt = 0;
        wb_cnt = 0;
        pend_cnt = 0;
        err_cnt = 0;
        test_err = 0;
        pass_tests = 0;
        fail_tests = 0;
        test_name = "reset";
    end

    function automatic logic [`OOO_XLEN-1:0] alu_model(ooo_pkg::alu_op_e op,
            logic [`OOO_XLEN-1:0] a, logic [`OOO_XLEN-1:0] b, logic [15:0] imm);
        case (op)
            ooo_pkg::ADD: return a + b;
            ooo_pkg::SUB: return a - b;
            ooo_pkg::AND: return a & b;
            ooo_pkg::OR:  return a | b;
            ooo_pkg::XOR: return a ^ b;
            ooo_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::LI:  return {{16{imm[15]}}, imm};
            default:      return '0;
        endcase
    endfunction

    function automatic bit tag_free(int t);
        return !pend_v[t];
    endfunction

    // free when no writer and no reader is still in flight
    function automatic bit reg_free(int r);
        return !wr_pend[r] && (rd_cnt[r] == 0);
    endfunction

    task automatic note_fail(string msg);
        $display("%s: %s", test_name, msg);
        test_err++;
        err_cnt++;
    endtask

    task automatic compare(string what, logic [31:0] exp_v, logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
            test_err++;
            err_cnt++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err = 0;
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            pass_tests++;
            $display("test %s: ok", test_name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", test_name, test_err);
        end
    endtask

    task automatic report();
        $display("tests ok %0d, failed %0d, errors %0d, writebacks %0d",
                 pass_tests, fail_tests, err_cnt, wb_cnt);
    endtask

    task automatic check_wb();
        int t;
        t = int'(wb_i.tag);
        if (!pend_v[t]) begin
            note_fail($sformatf("writeback with tag %0d has no pending micro-op", t));
            return;
        end
        for (int k = 0; k < 2; k++) begin
            if (dep_v[t][k] && pend_v[dep_tag[t][k]]
                    && (pend_seq[dep_tag[t][k]] == dep_seq[t][k])) begin
                note_fail($sformatf("tag %0d wrote back before its source", t));
            end
        end
        compare("dst", 32'(exp_dst[t]), 32'(wb_i.dst));
        compare("data", exp_data[t], wb_i.data);
        pend_v[t] = 1'b0;
        wr_pend[exp_dst[t]] = 1'b0;
        if (has_src[t]) begin
            rd_cnt[src_reg[t][0]]--;
            rd_cnt[src_reg[t][1]]--;
        end
        lat[t] = cyc - acc_cyc[t];
        wb_order[t] = wb_cnt;
        wb_cnt++;
        pend_cnt--;
    endtask

    task automatic record_uop();
        int t;
        int s [2];
        t = int'(uop_i.tag);
        s[0] = int'(uop_i.src1);
        s[1] = int'(uop_i.src2);
        if (pend_v[t]) begin
            note_fail($sformatf("tag %0d dispatched while still in flight", t));
        end
        has_src[t] = (uop_i.op != ooo_pkg::LI);
        for (int k = 0; k < 2; k++) begin
            src_reg[t][k] = s[k];
            dep_v[t][k] = has_src[t] && wr_pend[s[k]];
            dep_tag[t][k] = wr_tag[s[k]];
            dep_seq[t][k] = pend_seq[wr_tag[s[k]]];
            if (has_src[t]) begin
                rd_cnt[s[k]]++;
            end
        end
        exp_data[t] = alu_model(uop_i.op, model_q[s[0]], model_q[s[1]], uop_i.imm);
        exp_dst[t] = int'(uop_i.dst);
        model_q[uop_i.dst] = exp_data[t];
        wr_pend[uop_i.dst] = 1'b1;
        wr_tag[uop_i.dst] = t;
        pend_seq[t] = seq_cnt;
        seq_cnt++;
        pend_v[t] = 1'b1;
        acc_cyc[t] = cyc;
        pend_cnt++;
    endtask

    // writebacks first, a same-edge clear frees the register
    always @(posedge clk) begin
        cyc++;
        if (!rst && wb_valid_i) begin
            check_wb();
        end
        if (!rst && uop_valid_i && dispatch_ready_i) begin
            record_uop();
        end
    end

endmodule

/* tests/backend_assertions.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module backend_assertions (
    input logic clk,
    input logic rst,
    input logic iq_wr_i,
    input logic issue_i,
    input logic dispatch_ready_i,
    input logic wb_valid_i
);

    int inflight;
    // entries held in the issue queue, counted from writes and issues
    int iq_occ;
    int fail_cnt = 0;

    always @(posedge clk) begin
        if (rst) begin
            inflight <= 0;
            iq_occ   <= 0;
        end else begin
            inflight <= inflight + int'(iq_wr_i) - int'(wb_valid_i);
            iq_occ   <= iq_occ + int'(iq_wr_i) - int'(issue_i);
        end
    end

    a_wb_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wb_valid_i))
        else begin
            fail_cnt++;
            $error("wb_valid_o is unknown after reset");
        end

    a_wb_pending: assert property (@(posedge clk) disable iff (rst) wb_valid_i |-> inflight > 0)
        else begin
            fail_cnt++;
            $error("writeback without a pending dispatch");
        end

    a_accept_ready: assert property (@(posedge clk) disable iff (rst)
                                     iq_wr_i |-> iq_occ < `OOO_IQ_DEPTH)
        else begin
            fail_cnt++;
            $error("micro-op accepted while the queue is full");
        end

    a_ready_full: assert property (@(posedge clk) disable iff (rst)
                                   !dispatch_ready_i |-> iq_occ == `OOO_IQ_DEPTH)
        else begin
            fail_cnt++;
            $error("dispatch_ready_o low while the queue has room");
        end

endmodule

bind ooo_backend_top backend_assertions u_assert (
    .clk              (clk),
    .rst              (rst),
    .iq_wr_i          (iq_wr),
    .issue_i          (issue),
    .dispatch_ready_i (dispatch_ready_o),
    .wb_valid_i       (wb_valid_o)
);

/* verilog/ooo_backend_top.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_backend_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          uop_valid_i,
    input  ooo_pkg::uop_t uop_i,
    output logic          dispatch_ready_o,
    output logic          wb_valid_o,
    output ooo_pkg::wb_t  wb_o
);

    logic                  iq_wr;
    ooo_pkg::iq_entry_t    iq_entry;
    logic                  sb_set;
    logic [`OOO_PRF_W-1:0] sb_set_idx;
    logic [`OOO_PRF_W-1:0] src1_idx;
    logic [`OOO_PRF_W-1:0] src2_idx;
    logic                  src1_busy;
    logic                  src2_busy;
    logic                  issue;
    ooo_pkg::uop_t         issue_uop;
    logic [`OOO_PRF_W-1:0] ra1;
    logic [`OOO_PRF_W-1:0] ra2;
    logic [`OOO_XLEN-1:0]  rd1;
    logic [`OOO_XLEN-1:0]  rd2;

    dispatch_stage u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .uop_valid_i  (uop_valid_i),
        .uop_i        (uop_i),
        .iq_ready_i   (dispatch_ready_o),
        .src1_busy_i  (src1_busy),
        .src2_busy_i  (src2_busy),
        .iq_wr_o      (iq_wr),
        .iq_entry_o   (iq_entry),
        .sb_set_o     (sb_set),
        .sb_set_idx_o (sb_set_idx),
        .src1_idx_o   (src1_idx),
        .src2_idx_o   (src2_idx)
    );

    busy_scoreboard u_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .set_i     (sb_set),
        .set_idx_i (sb_set_idx),
        .clr_i     (wb_valid_o),
        .clr_wb_i  (wb_o),
        .rd1_idx_i (src1_idx),
        .rd2_idx_i (src2_idx),
        .busy1_o   (src1_busy),
        .busy2_o   (src2_busy)
    );

    alu_issue_queue u_iq (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (iq_wr),
        .entry_i     (iq_entry),
        .wb_valid_i  (wb_valid_o),
        .wb_i        (wb_o),
        .ready_o     (dispatch_ready_o),
        .issue_o     (issue),
        .issue_uop_o (issue_uop)
    );

    phys_regfile u_prf (
        .clk   (clk),
        .rst   (rst),
        .ra1_i (ra1),
        .ra2_i (ra2),
        .rd1_o (rd1),
        .rd2_o (rd2),
        .we_i  (wb_valid_o),
        .wb_i  (wb_o)
    );

    alu_execute u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue_i     (issue),
        .issue_uop_i (issue_uop),
        .rd1_i       (rd1),
        .rd2_i       (rd2),
        .ra1_o       (ra1),
        .ra2_o       (ra2),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

endmodule

/* verilog/alu_execute.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module alu_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_i,
    input  ooo_pkg::uop_t         issue_uop_i,
    input  logic [`OOO_XLEN-1:0]  rd1_i,
    input  logic [`OOO_XLEN-1:0]  rd2_i,
    output logic [`OOO_PRF_W-1:0] ra1_o,
    output logic [`OOO_PRF_W-1:0] ra2_o,
    output logic                  wb_valid_o,
    output ooo_pkg::wb_t          wb_o
);

    ooo_pkg::uop_t        s1_uop_q;
    logic                 s1_valid_q;
    logic [`OOO_XLEN-1:0] result;
    logic                 lt;

    // register file address comes straight from the issue slot
    assign ra1_o = issue_uop_i.src1;
    assign ra2_o = issue_uop_i.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            s1_uop_q <= issue_uop_i;
        end
    end

    assign lt = $signed(rd1_i) < $signed(rd2_i);

    always_comb begin
        case (s1_uop_q.op)
            ooo_pkg::ADD: result = rd1_i + rd2_i;
            ooo_pkg::SUB: result = rd1_i - rd2_i;
            ooo_pkg::AND: result = rd1_i & rd2_i;
            ooo_pkg::OR:  result = rd1_i | rd2_i;
            ooo_pkg::XOR: result = rd1_i ^ rd2_i;
            ooo_pkg::SLT: result = {{(`OOO_XLEN-1){1'b0}}, lt};
            ooo_pkg::LI:  result = {{(`OOO_XLEN-16){s1_uop_q.imm[15]}}, s1_uop_q.imm};
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            wb_o.tag  <= s1_uop_q.tag;
            wb_o.dst  <= s1_uop_q.dst;
            wb_o.data <= result;
        end
    end

endmodule

/* verilog/phys_regfile.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`OOO_PRF_W-1:0] ra1_i,
    input  logic [`OOO_PRF_W-1:0] ra2_i,
    output logic [`OOO_XLEN-1:0]  rd1_o,
    output logic [`OOO_XLEN-1:0]  rd2_o,
    input  logic                  we_i,
    input  ooo_pkg::wb_t          wb_i
);

    logic [`OOO_XLEN-1:0]    mem_q [`OOO_PRF_NUM];
    // registers never written read as zero
    logic [`OOO_PRF_NUM-1:0] written_q;

    function automatic logic [`OOO_XLEN-1:0] read_word(input logic [`OOO_PRF_W-1:0] addr);
        logic [`OOO_XLEN-1:0] w;
        if (we_i && (wb_i.dst == addr)) begin
            w = wb_i.data;
        end else if (written_q[addr]) begin
            w = mem_q[addr];
        end else begin
            w = '0;
        end
        return w;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            written_q <= '0;
        end else if (we_i) begin
            written_q[wb_i.dst] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[wb_i.dst] <= wb_i.data;
        end
    end

    // synchronous read, same-cycle write passes through
    always_ff @(posedge clk) begin
        rd1_o <= read_word(ra1_i);
        rd2_o <= read_word(ra2_i);
    end

endmodule

/* verilog/alu_issue_queue.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module alu_issue_queue (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_i,
    input  ooo_pkg::iq_entry_t entry_i,
    input  logic               wb_valid_i,
    input  ooo_pkg::wb_t       wb_i,
    output logic               ready_o,
    output logic               issue_o,
    output ooo_pkg::uop_t      issue_uop_o
);

    localparam int DEPTH = `OOO_IQ_DEPTH;
    localparam int IDX_W = $clog2(`OOO_IQ_DEPTH);

    ooo_pkg::iq_entry_t slot_q [DEPTH];
    logic [DEPTH-1:0]   valid_q;
    // older_q[i][j] is set when entry j is older than entry i
    logic [DEPTH-1:0]   older_q [DEPTH];
    logic [DEPTH-1:0]   can_issue;
    logic [DEPTH-1:0]   sel;
    logic [IDX_W-1:0]   sel_idx;
    logic [IDX_W-1:0]   free_idx;

    function automatic ooo_pkg::iq_entry_t wake(
        input ooo_pkg::iq_entry_t    e,
        input logic                  hit_en,
        input logic [`OOO_PRF_W-1:0] dst
    );
        ooo_pkg::iq_entry_t r;
        r = e;
        if (hit_en && (e.uop.src1 == dst)) begin
            r.src1_rdy = 1'b1;
        end
        if (hit_en && (e.uop.src2 == dst)) begin
            r.src2_rdy = 1'b1;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            can_issue[i] = valid_q[i] & slot_q[i].src1_rdy & slot_q[i].src2_rdy;
        end
    end

    // oldest ready: no older entry is also ready
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            sel[i] = can_issue[i] & ~|(can_issue & older_q[i]);
        end
    end

    always_comb begin
        sel_idx  = '0;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (sel[i]) begin
                sel_idx = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign ready_o     = ~&valid_q;
    assign issue_o     = |sel;
    assign issue_uop_o = slot_q[sel_idx].uop;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (sel[i]) begin
                    valid_q[i] <= 1'b0;
                end
                // new entry is younger than everything
                if (wr_i) begin
                    older_q[i][free_idx] <= 1'b0;
                end
            end
            if (wr_i) begin
                valid_q[free_idx] <= 1'b1;
                older_q[free_idx] <= valid_q & ~sel;
            end
        end
    end

    // wakeup also covers the entry written this cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_q[i] <= wake(slot_q[i], wb_valid_i, wb_i.dst);
        end
        if (wr_i) begin
            slot_q[free_idx] <= wake(entry_i, wb_valid_i, wb_i.dst);
        end
    end

endmodule

/* verilog/busy_scoreboard.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module busy_scoreboard (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  set_i,
    input  logic [`OOO_PRF_W-1:0] set_idx_i,
    input  logic                  clr_i,
    input  ooo_pkg::wb_t          clr_wb_i,
    input  logic [`OOO_PRF_W-1:0] rd1_idx_i,
    input  logic [`OOO_PRF_W-1:0] rd2_idx_i,
    output logic                  busy1_o,
    output logic                  busy2_o
);

    logic [`OOO_PRF_NUM-1:0] busy_q;
    logic                    clr_hit1;
    logic                    clr_hit2;

    // a writeback in this cycle already counts as ready
    assign clr_hit1 = clr_i && (clr_wb_i.dst == rd1_idx_i);
    assign clr_hit2 = clr_i && (clr_wb_i.dst == rd2_idx_i);

    assign busy1_o = busy_q[rd1_idx_i] & ~clr_hit1;
    assign busy2_o = busy_q[rd2_idx_i] & ~clr_hit2;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (clr_i) begin
                busy_q[clr_wb_i.dst] <= 1'b0;
            end
            // set after clear, so a new producer wins
            if (set_i) begin
                busy_q[set_idx_i] <= 1'b1;
            end
        end
    end

endmodule

/* verilog/dispatch_stage.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module dispatch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uop_valid_i,
    input  ooo_pkg::uop_t         uop_i,
    input  logic                  iq_ready_i,
    input  logic                  src1_busy_i,
    input  logic                  src2_busy_i,
    output logic                  iq_wr_o,
    output ooo_pkg::iq_entry_t    iq_entry_o,
    output logic                  sb_set_o,
    output logic [`OOO_PRF_W-1:0] sb_set_idx_o,
    output logic [`OOO_PRF_W-1:0] src1_idx_o,
    output logic [`OOO_PRF_W-1:0] src2_idx_o
);

    logic accept;
    logic no_src;
    logic pend1;
    logic pend2;

    assign accept = uop_valid_i & iq_ready_i;
    assign no_src = (uop_i.op == ooo_pkg::LI);

    assign src1_idx_o = uop_i.src1;
    assign src2_idx_o = uop_i.src2;

    // busy set reaches the scoreboard one edge after accept
    always_ff @(posedge clk) begin
        if (rst) begin
            sb_set_o <= 1'b0;
        end else begin
            sb_set_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sb_set_idx_o <= uop_i.dst;
        end
    end

    // previous dst not yet visible in the scoreboard
    assign pend1 = sb_set_o && (sb_set_idx_o == uop_i.src1);
    assign pend2 = sb_set_o && (sb_set_idx_o == uop_i.src2);

    assign iq_wr_o             = accept;
    assign iq_entry_o.uop      = uop_i;
    assign iq_entry_o.src1_rdy = no_src | ~(src1_busy_i | pend1);
    assign iq_entry_o.src2_rdy = no_src | ~(src2_busy_i | pend2);

endmodule

/* verilog/ooo_pkg.sv */
`include "ooo_settings.svh"

package ooo_pkg;

    // alu opcodes, li takes no sources
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5,
        LI  = 3'd6
    } alu_op_e;

    // one renamed micro-op, physical indices already assigned
    typedef struct packed {
        logic [`OOO_TAG_W-1:0] tag;
        alu_op_e               op;
        logic [`OOO_PRF_W-1:0] src1;
        logic [`OOO_PRF_W-1:0] src2;
        logic [`OOO_PRF_W-1:0] dst;
        logic [15:0]           imm;
    } uop_t;

    // queue entry with per-source ready bits
    typedef struct packed {
        uop_t uop;
        logic src1_rdy;
        logic src2_rdy;
    } iq_entry_t;

    // writeback broadcast
    typedef struct packed {
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_PRF_W-1:0] dst;
        logic [`OOO_XLEN-1:0]  data;
    } wb_t;

endpackage

/* verilog/ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// physical register file, one data word per entry
`define OOO_PRF_NUM 64

// index into the physical register file
`define OOO_PRF_W 6

// micro-op tag, carried through to writeback
`define OOO_TAG_W 6

// data path width
`define OOO_XLEN 32

// alu issue queue entries
`define OOO_IQ_DEPTH 8

`endif
